// File: ckeGenerator.sv
// Clock-enable generator that pulses divCke once every spiDiv+1 sClk cycles
`include "spi_consts.svh"

module ckeGenerator import spiPkg::*; (
	input logic sClk,
	input logic reset,
	input logic spiEn,
	input spiDiv_t spiDiv,
	output logic divCke
);

	spiDiv_t divReg;
	spiDiv_t divCnt;

	// Divider value from the CSR, one cycle late
	always_ff @(posedge sClk)
	begin
		divReg <= spiDiv;
	end

	// Down-counter, reload and pulse at zero
	always_ff @(posedge sClk)
	begin
		if (reset || !spiEn)
		begin
			divCnt <= '0;
			divCke <= 1'b0;
		end
		else if (divCnt == `SPI_DIV_WIDTH'(0))
		begin
			divCnt <= divReg;
			divCke <= 1'b1;
		end
		else
		begin
			divCnt <= divCnt - `SPI_DIV_WIDTH'(1);
			divCke <= 1'b0;
		end
	end

endmodule

// File: sources.f
+incdir+.
spiPkg.sv
ckeGenerator.sv
spiMasterShifter.sv
spiSlaveReceiver.sv
spiFrameDecoder.sv
spiUnit.sv
spiUnitTb.sv

// File: spiFrameDecoder.sv
// Slave frame decoder that turns command, address and data bytes into register bus cycles
`include "spi_consts.svh"

module spiFrameDecoder import spiPkg::*; (
	input logic sClk,
	input logic reset,
	input logic frameStart,
	input spiByte_t rxByte,
	input logic rxStrobe,
	output spiByte_t txByte,
	output usiAdrs_t usiAdrs,
	output usiData_t usiWd,
	output logic usiWEd,
	input usiData_t usiRd
);

	decodeState_t state;
	logic isRead;
	logic [1:0] byteCnt;
	// Read word fetch, request then capture
	logic rdReq;
	logic rdCap;
	usiData_t rdWord;

	// ----------------------------------------------
	// Command FSM
	// ----------------------------------------------
	always_ff @(posedge sClk)
	begin
		if (reset || frameStart)
		begin
			state <= DS_CMD;
			isRead <= 1'b0;
			byteCnt <= 2'd0;
			rdReq <= 1'b0;
			rdCap <= 1'b0;
			txByte <= '0;
			usiWEd <= 1'b0;
			if (reset)
				usiAdrs <= '0;
		end
		else
		begin
			rdReq <= 1'b0;
			rdCap <= rdReq;
			usiWEd <= 1'b0;
			// Step past a word just written
			if (usiWEd)
				usiAdrs <= usiAdrs + `SPI_ADRS_WIDTH'(4);
			// Top byte of the fetched word goes out first
			if (rdCap)
				txByte <= usiRd[`SPI_DATA_WIDTH-1 -: 8];
			if (rxStrobe)
			begin
				case (state)
					DS_CMD:
					begin
						isRead <= (rxByte == `SPI_CMD_READ);
						if ((rxByte == `SPI_CMD_WRITE) || (rxByte == `SPI_CMD_READ))
							state <= DS_ADRS_HI;
						else
							state <= DS_IGNORE;
					end
					DS_ADRS_HI:
					begin
						usiAdrs[`SPI_ADRS_WIDTH-1:8] <= rxByte;
						state <= DS_ADRS_LO;
					end
					DS_ADRS_LO:
					begin
						usiAdrs[7:0] <= rxByte;
						state <= isRead ? DS_READ : DS_WRITE;
						rdReq <= isRead;
					end
					DS_WRITE:
					begin
						byteCnt <= byteCnt + 2'd1;
						// Fourth byte completes the word
						usiWEd <= (byteCnt == 2'd3);
					end
					DS_READ:
					begin
						byteCnt <= byteCnt + 2'd1;
						if (byteCnt == 2'd3)
						begin
							usiAdrs <= usiAdrs + `SPI_ADRS_WIDTH'(4);
							rdReq <= 1'b1;
						end
						else
							txByte <= rdWord[`SPI_DATA_WIDTH-9 -: 8];
					end
					// Unknown command, wait for the next frame
					default:
						state <= DS_IGNORE;
				endcase
			end
		end
	end

	// ----------------------------------------------
	// Write packer and read word holder
	// ----------------------------------------------
	always_ff @(posedge sClk)
	begin
		if (rxStrobe && (state == DS_WRITE))
			usiWd <= {usiWd[`SPI_DATA_WIDTH-9:0], rxByte};
		if (rdCap)
			rdWord <= usiRd;
		else if (rxStrobe && (state == DS_READ))
			rdWord <= {rdWord[`SPI_DATA_WIDTH-9:0], 8'h00};
	end

endmodule

// File: spiMasterShifter.sv
// SPI master byte engine, mode 0, MSB first, with a done interrupt pulse
`include "spi_consts.svh"

module spiMasterShifter import spiPkg::*; (
	input logic sClk,
	input logic reset,
	input logic spiEn,
	input logic divCke,
	input logic masterWrite,
	input spiByte_t masterWd,
	output spiByte_t masterRd,
	output logic masterBusy,
	output logic masterIntr,
	output logic spiSck,
	output logic spiMosi,
	input logic spiMiso
);

	masterState_t state;
	spiByte_t txShift;
	spiByte_t rxShift;
	// Counts completed falling edges
	logic [3:0] bitCnt;
	logic accept;
	logic riseStep;
	logic fallStep;
	logic done;
	logic abort;

	// ----------------------------------------------
	// Step conditions
	// ----------------------------------------------
	assign accept = (state == MS_IDLE) && masterWrite && spiEn;
	// Eight falls seen, finish in the following cycle
	assign done = (state == MS_LOW) && (bitCnt == 4'd8);
	assign riseStep = (state == MS_LOW) && spiEn && divCke && !done;
	assign fallStep = (state == MS_HIGH) && spiEn && divCke;
	// Enable dropped mid-byte
	assign abort = (state != MS_IDLE) && !spiEn && !done;

	// ----------------------------------------------
	// Control FSM
	// ----------------------------------------------
	always_ff @(posedge sClk)
	begin
		if (reset)
		begin
			state <= MS_IDLE;
			bitCnt <= 4'd0;
			masterBusy <= 1'b0;
			masterIntr <= 1'b0;
			masterRd <= '0;
			spiSck <= 1'b0;
			spiMosi <= 1'b0;
		end
		else
		begin
			masterIntr <= 1'b0;
			if (accept)
			begin
				state <= MS_LOW;
				bitCnt <= 4'd0;
				masterBusy <= 1'b1;
				// First bit set up before the first rise
				spiMosi <= masterWd[7];
			end
			else if (done)
			begin
				state <= MS_IDLE;
				masterBusy <= 1'b0;
				masterIntr <= 1'b1;
				masterRd <= rxShift;
			end
			else if (abort)
			begin
				state <= MS_IDLE;
				masterBusy <= 1'b0;
				spiSck <= 1'b0;
			end
			else if (riseStep)
			begin
				state <= MS_HIGH;
				spiSck <= 1'b1;
			end
			else if (fallStep)
			begin
				state <= MS_LOW;
				spiSck <= 1'b0;
				spiMosi <= txShift[6];
				bitCnt <= bitCnt + 4'd1;
			end
		end
	end

	// Data shifters
	always_ff @(posedge sClk)
	begin
		if (accept)
			txShift <= masterWd;
		else if (fallStep)
			txShift <= {txShift[6:0], 1'b0};
		// MISO taken as SCK rises
		if (riseStep)
			rxShift <= {rxShift[6:0], spiMiso};
	end

endmodule

// File: spiPkg.sv
// SPI unit package holding the width typedefs and the FSM state types
`include "spi_consts.svh"

package spiPkg;

	// One serial byte on MOSI or MISO
	typedef logic [7:0] spiByte_t;
	// Register bus address and word
	typedef logic [`SPI_ADRS_WIDTH-1:0] usiAdrs_t;
	typedef logic [`SPI_DATA_WIDTH-1:0] usiData_t;
	// Master bit rate divider
	typedef logic [`SPI_DIV_WIDTH-1:0] spiDiv_t;

	// Slave frame decoder states
	typedef enum logic [2:0] {
		DS_CMD,
		DS_ADRS_HI,
		DS_ADRS_LO,
		DS_WRITE,
		DS_READ,
		DS_IGNORE
	} decodeState_t;

	// Master byte engine states
	typedef enum logic [1:0] {MS_IDLE, MS_LOW, MS_HIGH} masterState_t;

endpackage

// File: spiSlaveReceiver.sv
// SPI slave front end that syncs the pins and moves bytes in on MOSI and out on MISO
`include "spi_consts.svh"

module spiSlaveReceiver import spiPkg::*; (
	input logic sClk,
	input logic reset,
	input logic spiSlaveSck,
	input logic spiSlaveCs,
	input logic spiSlaveMosi,
	output logic spiSlaveMiso,
	output spiByte_t rxByte,
	output logic rxStrobe,
	output logic frameStart,
	input spiByte_t txByte
);

	logic [`SPI_SYNC_STAGES-1:0] sckSync;
	logic [`SPI_SYNC_STAGES-1:0] csSync;
	logic [`SPI_SYNC_STAGES-1:0] mosiSync;
	logic sckPrev;
	logic csPrev;
	logic sckRise;
	logic sckFall;
	logic csFall;
	logic csHigh;
	logic mosiBit;
	logic csLoad;
	logic [2:0] bitCnt;
	spiByte_t rxShift;
	spiByte_t misoShift;

	// ----------------------------------------------
	// Pin synchronizers and edge detect
	// ----------------------------------------------
	always_ff @(posedge sClk)
	begin
		if (reset)
		begin
			sckSync <= '0;
			// Chip select idles high
			csSync <= '1;
			mosiSync <= '0;
			sckPrev <= 1'b0;
			csPrev <= 1'b1;
		end
		else
		begin
			sckSync <= {sckSync[`SPI_SYNC_STAGES-2:0], spiSlaveSck};
			csSync <= {csSync[`SPI_SYNC_STAGES-2:0], spiSlaveCs};
			mosiSync <= {mosiSync[`SPI_SYNC_STAGES-2:0], spiSlaveMosi};
			sckPrev <= sckSync[`SPI_SYNC_STAGES-1];
			csPrev <= csSync[`SPI_SYNC_STAGES-1];
		end
	end

	assign csHigh = csSync[`SPI_SYNC_STAGES-1];
	assign mosiBit = mosiSync[`SPI_SYNC_STAGES-1];
	assign csFall = !csHigh && csPrev;
	// SCK edges count only inside a frame
	assign sckRise = sckSync[`SPI_SYNC_STAGES-1] && !sckPrev && !csHigh;
	assign sckFall = !sckSync[`SPI_SYNC_STAGES-1] && sckPrev && !csHigh;

	// MSB of the MISO shifter straight to the pin
	assign spiSlaveMiso = misoShift[7];

	// ----------------------------------------------
	// Bit counter, strobes and MISO shifter
	// ----------------------------------------------
	always_ff @(posedge sClk)
	begin
		if (reset)
		begin
			bitCnt <= 3'd0;
			rxStrobe <= 1'b0;
			frameStart <= 1'b0;
			csLoad <= 1'b0;
			misoShift <= '0;
		end
		else
		begin
			rxStrobe <= sckRise && (bitCnt == 3'd7);
			frameStart <= csFall;
			// First byte loaded after the decoder has restarted
			csLoad <= frameStart;
			if (csHigh)
			begin
				bitCnt <= 3'd0;
				misoShift <= '0;
			end
			else
			begin
				if (sckRise)
					bitCnt <= bitCnt + 3'd1;
				if (csLoad)
					misoShift <= txByte;
				else if (sckFall && (bitCnt == 3'd0))
					misoShift <= txByte;
				else if (sckFall)
					misoShift <= {misoShift[6:0], 1'b0};
			end
		end
	end

	// MOSI deserializer
	always_ff @(posedge sClk)
	begin
		if (sckRise)
			rxShift <= {rxShift[6:0], mosiBit};
		if (sckRise && (bitCnt == 3'd7))
			rxByte <= {rxShift[6:0], mosiBit};
	end

endmodule

// File: spiUnit.sv
// SPI control unit top with a master byte engine and a slave register bus bridge
`include "spi_consts.svh"

module spiUnit import spiPkg::*; (
	input logic sClk,
	input logic reset,
	// Master CSRs
	input logic spiEn,
	input spiDiv_t spiDiv,
	input logic masterWrite,
	input spiByte_t masterWd,
	input logic masterCs,
	output spiByte_t masterRd,
	output logic masterBusy,
	output logic masterIntr,
	// Master pins
	output logic spiSck,
	output logic spiMosi,
	input logic spiMiso,
	output logic spiCs,
	// Slave pins
	input logic spiSlaveSck,
	input logic spiSlaveCs,
	input logic spiSlaveMosi,
	output logic spiSlaveMiso,
	// Register bus
	output usiAdrs_t usiAdrs,
	output usiData_t usiWd,
	output logic usiWEd,
	input usiData_t usiRd
);

	logic divCke;
	logic rxStrobe;
	logic frameStart;
	spiByte_t rxByte;
	spiByte_t txByte;

	// Master chip select is a plain CSR level
	assign spiCs = masterCs;

	// ----------------------------------------------
	// Master path
	// ----------------------------------------------
	ckeGenerator ckeGen (
		.sClk(sClk),
		.reset(reset),
		.spiEn(spiEn),
		.spiDiv(spiDiv),
		.divCke(divCke)
	);

	spiMasterShifter masterShifter (
		.sClk(sClk),
		.reset(reset),
		.spiEn(spiEn),
		.divCke(divCke),
		.masterWrite(masterWrite),
		.masterWd(masterWd),
		.masterRd(masterRd),
		.masterBusy(masterBusy),
		.masterIntr(masterIntr),
		.spiSck(spiSck),
		.spiMosi(spiMosi),
		.spiMiso(spiMiso)
	);

	// ----------------------------------------------
	// Slave path
	// ----------------------------------------------
	spiSlaveReceiver slaveReceiver (
		.sClk(sClk),
		.reset(reset),
		.spiSlaveSck(spiSlaveSck),
		.spiSlaveCs(spiSlaveCs),
		.spiSlaveMosi(spiSlaveMosi),
		.spiSlaveMiso(spiSlaveMiso),
		.rxByte(rxByte),
		.rxStrobe(rxStrobe),
		.frameStart(frameStart),
		.txByte(txByte)
	);

	spiFrameDecoder frameDecoder (
		.sClk(sClk),
		.reset(reset),
		.frameStart(frameStart),
		.rxByte(rxByte),
		.rxStrobe(rxStrobe),
		.txByte(txByte),
		.usiAdrs(usiAdrs),
		.usiWd(usiWd),
		.usiWEd(usiWEd),
		.usiRd(usiRd)
	);

endmodule

// File: spiUnitTb.sv
// Directed testbench for the SPI unit with SPI master, SPI slave and register memory models
`include "spi_consts.svh"

module spiUnitTb import spiPkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	// Slave-side SCK half-period in sClk cycles
	localparam int HALF = 10;

	logic sClk;
	logic reset;
	logic spiEn;
	spiDiv_t spiDiv;
	logic masterWrite;
	spiByte_t masterWd;
	logic masterCs;
	spiByte_t masterRd;
	logic masterBusy;
	logic masterIntr;
	logic spiSck;
	logic spiMosi;
	logic spiMiso;
	logic spiCs;
	logic spiSlaveSck;
	logic spiSlaveCs;
	logic spiSlaveMosi;
	logic spiSlaveMiso;
	usiAdrs_t usiAdrs;
	usiData_t usiWd;
	logic usiWEd;
	usiData_t usiRd;

	// Register memory contents and the write log
	usiData_t mem [0:65535];
	usiAdrs_t wrAdrs [$];
	usiData_t wrData [$];

	spiUnit dut (
		.sClk(sClk),
		.reset(reset),
		.spiEn(spiEn),
		.spiDiv(spiDiv),
		.masterWrite(masterWrite),
		.masterWd(masterWd),
		.masterCs(masterCs),
		.masterRd(masterRd),
		.masterBusy(masterBusy),
		.masterIntr(masterIntr),
		.spiSck(spiSck),
		.spiMosi(spiMosi),
		.spiMiso(spiMiso),
		.spiCs(spiCs),
		.spiSlaveSck(spiSlaveSck),
		.spiSlaveCs(spiSlaveCs),
		.spiSlaveMosi(spiSlaveMosi),
		.spiSlaveMiso(spiSlaveMiso),
		.usiAdrs(usiAdrs),
		.usiWd(usiWd),
		.usiWEd(usiWEd),
		.usiRd(usiRd)
	);

	// 8 ns clock
	always #4 sClk = ~sClk;

	// --------------------------------------------------
	// Register bus model
	// --------------------------------------------------
	// Read data one cycle after the address
	always @(posedge sClk)
	begin
		usiRd <= mem[usiAdrs];
	end

	// Write strobes logged mid-cycle
	always @(negedge sClk)
	begin
		if (usiWEd === 1'b1)
		begin
			wrAdrs.push_back(usiAdrs);
			wrData.push_back(usiWd);
		end
	end

	// --------------------------------------------------
	// Failure reporting and compare tasks
	// --------------------------------------------------
	task automatic stopRun();
		$display(">>> FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic reportFailure(input string msg);
		$display("ERROR: %s", msg);
		stopRun();
	endtask

	task automatic checkByte(input string name, input spiByte_t got, input spiByte_t exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkWord(input string name, input usiData_t got, input usiData_t exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkAdrs(input string name, input usiAdrs_t got, input usiAdrs_t exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
			stopRun();
		end
	endtask

	// --------------------------------------------------
	// SPI master model for the slave pins
	// --------------------------------------------------
	task automatic waitCycles(input int n);
		repeat (n) @(negedge sClk);
	endtask

	task automatic openFrame();
		spiSlaveCs = 1'b0;
		waitCycles(HALF);
	endtask

	task automatic closeFrame();
		waitCycles(HALF);
		spiSlaveCs = 1'b1;
		waitCycles(2 * HALF);
	endtask

	// Mode 0 byte exchange with MISO taken as SCK rises
	task automatic shiftSlaveByte(input spiByte_t outByte, output spiByte_t inByte);
		for (int i = 7; i >= 0; i--)
		begin
			spiSlaveMosi = outByte[i];
			waitCycles(HALF);
			spiSlaveSck = 1'b1;
			inByte[i] = spiSlaveMiso;
			waitCycles(HALF);
			spiSlaveSck = 1'b0;
		end
	endtask

	// --------------------------------------------------
	// Directed tests
	// --------------------------------------------------
	task automatic resetDefaults();
		checkBit("usiWEd", usiWEd, 1'b0);
		checkBit("masterIntr", masterIntr, 1'b0);
		checkBit("masterBusy", masterBusy, 1'b0);
		checkBit("spiSck", spiSck, 1'b0);
		checkBit("spiMosi", spiMosi, 1'b0);
		checkBit("spiSlaveMiso", spiSlaveMiso, 1'b0);
	endtask

	task automatic slaveWriteFrame();
		usiAdrs_t base;
		usiData_t words [3];
		spiByte_t dummy;
		int guard;
		base = usiAdrs_t'($urandom());
		for (int w = 0; w < 3; w++)
			words[w] = $urandom();
		wrAdrs.delete();
		wrData.delete();
		openFrame();
		shiftSlaveByte(`SPI_CMD_WRITE, dummy);
		shiftSlaveByte(base[15:8], dummy);
		shiftSlaveByte(base[7:0], dummy);
		// Words go out MSB first
		for (int w = 0; w < 3; w++)
			for (int b = 3; b >= 0; b--)
				shiftSlaveByte(words[w][8*b +: 8], dummy);
		guard = 0;
		while (wrAdrs.size() < 3)
		begin
			@(negedge sClk);
			guard++;
			if (guard > 200)
				reportFailure("slave write frame did not produce three usiWEd pulses");
		end
		closeFrame();
		checkWord("usiWEd count", usiData_t'(wrAdrs.size()), 32'd3);
		for (int w = 0; w < 3; w++)
		begin
			checkAdrs("usiAdrs", wrAdrs[w], base + usiAdrs_t'(4 * w));
			checkWord("usiWd", wrData[w], words[w]);
		end
	endtask

	task automatic slaveReadFrame();
		usiAdrs_t base;
		usiData_t words [2];
		spiByte_t got;
		spiByte_t dummy;
		base = usiAdrs_t'($urandom());
		for (int w = 0; w < 2; w++)
		begin
			words[w] = $urandom();
			mem[base + usiAdrs_t'(4 * w)] = words[w];
		end
		openFrame();
		shiftSlaveByte(`SPI_CMD_READ, dummy);
		shiftSlaveByte(base[15:8], dummy);
		shiftSlaveByte(base[7:0], dummy);
		for (int w = 0; w < 2; w++)
			for (int b = 3; b >= 0; b--)
			begin
				shiftSlaveByte(8'h00, got);
				checkByte("spiSlaveMiso", got, words[w][8*b +: 8]);
			end
		closeFrame();
	endtask

	task automatic slaveIgnoredCommand();
		spiByte_t got;
		wrAdrs.delete();
		openFrame();
		shiftSlaveByte(8'h5A, got);
		checkByte("spiSlaveMiso", got, 8'h00);
		// Data bytes after an unknown command
		for (int i = 0; i < 6; i++)
		begin
			shiftSlaveByte(spiByte_t'($urandom()), got);
			checkByte("spiSlaveMiso", got, 8'h00);
		end
		closeFrame();
		checkWord("usiWEd count", usiData_t'(wrAdrs.size()), 32'd0);
	endtask

	task automatic masterTransfer();
		spiDiv_t div;
		spiByte_t wd;
		spiByte_t retByte;
		spiByte_t mosiByte;
		logic prevSck;
		int guard;
		int sinceEdge;
		int edges;
		int falls;
		int intrCount;
		div = spiDiv_t'(1 + ($urandom() % 4));
		wd = spiByte_t'($urandom());
		retByte = spiByte_t'($urandom());
		masterCs = 1'b0;
		spiDiv = div;
		// Slave model sets up its first bit
		spiMiso = retByte[7];
		waitCycles(2);
		checkBit("spiCs", spiCs, 1'b0);
		spiEn = 1'b1;
		waitCycles(4);
		masterWd = wd;
		masterWrite = 1'b1;
		@(negedge sClk);
		masterWrite = 1'b0;
		checkBit("masterBusy", masterBusy, 1'b1);
		prevSck = spiSck;
		mosiByte = '0;
		guard = 0;
		sinceEdge = 0;
		edges = 0;
		falls = 0;
		intrCount = 0;
		while (intrCount == 0)
		begin
			@(negedge sClk);
			guard++;
			sinceEdge++;
			if (guard > 1000)
				reportFailure("master transfer did not raise masterIntr within 1000 cycles");
			if (spiSck !== prevSck)
			begin
				// First low half starts at an arbitrary divider phase
				if (edges > 0)
					checkWord("sckHalfPeriod", usiData_t'(sinceEdge), usiData_t'(div) + 1);
				edges++;
				sinceEdge = 0;
				prevSck = spiSck;
				if (spiSck)
					mosiByte = {mosiByte[6:0], spiMosi};
				else
				begin
					falls++;
					if (falls < 8)
						spiMiso = retByte[7 - falls];
				end
			end
			if (masterIntr === 1'b1)
			begin
				intrCount++;
				checkWord("masterIntr delay", usiData_t'(sinceEdge), 32'd1);
				checkByte("masterRd", masterRd, retByte);
				checkBit("masterBusy", masterBusy, 1'b0);
			end
		end
		// No second pulse afterwards
		for (int i = 0; i < 20; i++)
		begin
			@(negedge sClk);
			if (masterIntr === 1'b1)
				intrCount++;
		end
		checkWord("sckEdges", usiData_t'(edges), 32'd16);
		checkByte("spiMosi", mosiByte, wd);
		checkWord("masterIntr count", usiData_t'(intrCount), 32'd1);
		masterCs = 1'b1;
		waitCycles(1);
		checkBit("spiCs", spiCs, 1'b1);
	endtask

	task automatic masterDisabled();
		logic sckBefore;
		spiEn = 1'b0;
		waitCycles(4);
		sckBefore = spiSck;
		masterWd = spiByte_t'($urandom());
		masterWrite = 1'b1;
		@(negedge sClk);
		masterWrite = 1'b0;
		for (int i = 0; i < 100; i++)
		begin
			checkBit("masterBusy", masterBusy, 1'b0);
			checkBit("spiSck", spiSck, sckBefore);
			@(negedge sClk);
		end
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial
	begin
		void'($urandom(32'h988bc04a));
		sClk = 1'b0;
		reset = 1'b1;
		spiEn = 1'b0;
		spiDiv = '0;
		masterWrite = 1'b0;
		masterWd = '0;
		masterCs = 1'b1;
		spiMiso = 1'b0;
		spiSlaveSck = 1'b0;
		spiSlaveCs = 1'b1;
		spiSlaveMosi = 1'b0;
		usiRd = '0;
		// Background contents that differ at every address
		for (int a = 0; a < 65536; a++)
			mem[a] = {16'(a) ^ 16'hA5C3, ~16'(a)};
		repeat (4) @(negedge sClk);
		reset = 1'b0;
		resetDefaults();
		waitCycles(4);
		slaveWriteFrame();
		slaveReadFrame();
		slaveIgnoredCommand();
		masterTransfer();
		masterDisabled();
		$display(">>> PASS");
		$finish;
	end

endmodule

// File: spi_consts.svh
// SPI unit constants for command codes, bus widths and synchronizer depth
`ifndef SPI_CONSTS_SVH
`define SPI_CONSTS_SVH

// ----------------------------------------------
// Slave frame command bytes
// ----------------------------------------------
`define SPI_CMD_WRITE 8'h01
`define SPI_CMD_READ 8'h02

// ----------------------------------------------
// Register bus and divider widths
// ----------------------------------------------
`define SPI_ADRS_WIDTH 16
`define SPI_DATA_WIDTH 32
`define SPI_DIV_WIDTH 16
// Flops in front of the slave pins
`define SPI_SYNC_STAGES 2
`endif
